//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_core_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/register_bank.sv
      - rtl/execute_stage.sv
      - rtl/rv_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_rv_core.sv

//--- build.f
+incdir+testbench
rtl/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_bank.sv
rtl/execute_stage.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

//--- rtl/decode_stage.sv
// instruction decode, immediate build and the decode to execute register
// operands come from the register bank, bypass included
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        enable_i,
    input  word_t       instruction_i,
    input  word_t       pc_i,
    input  tag_t        tag_i,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    input  word_t       rs1_data_i,
    input  word_t       rs2_data_i,
    output decode_out_t decoded_o
);

    word_t       instr;
    word_t       held_instr_q;
    logic        stalled_q;
    rv_opcode_e  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       imm_i;
    word_t       imm_u;
    word_t       imm_b;
    word_t       imm_j;
    decode_out_t next;

    // funct3/funct7 to alu operation, bad encodings become nop
    function automatic alu_op_e alu_decode(logic [2:0] f3, logic [6:0] f7, logic is_imm);
        alu_op_e op;
        logic    f7_zero;
        logic    f7_alt;
        f7_zero = (f7 == 7'b0000000);
        f7_alt  = (f7 == 7'b0100000);
        op      = OP_NOP;
        case (f3)
            3'b000: begin
                if (is_imm || f7_zero) begin
                    op = ALU_ADD;
                end else if (f7_alt) begin
                    op = ALU_SUB;
                end
            end
            3'b001: op = f7_zero ? ALU_SLL : OP_NOP;
            3'b010: op = (is_imm || f7_zero) ? ALU_SLT : OP_NOP;
            3'b011: op = (is_imm || f7_zero) ? ALU_SLTU : OP_NOP;
            3'b100: op = (is_imm || f7_zero) ? ALU_XOR : OP_NOP;
            3'b101: op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : OP_NOP);
            3'b110: op = (is_imm || f7_zero) ? ALU_OR : OP_NOP;
            default: op = (is_imm || f7_zero) ? ALU_AND : OP_NOP;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stall capture
    ////////////////////////////////////////////////////////////////////////////
    // memory moves on to the next address during a stall
    // so keep the word seen in the first stalled cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            stalled_q <= 1'b0;
        end else begin
            stalled_q <= ~enable_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!enable_i && !stalled_q) begin
            held_instr_q <= instruction_i;
        end
    end

    assign instr = stalled_q ? held_instr_q : instruction_i;

    ////////////////////////////////////////////////////////////////////////////
    // field decode
    ////////////////////////////////////////////////////////////////////////////
    assign opcode = rv_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    // immediates, sign from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        next.op             = OP_NOP;
        next.pc             = pc_i;
        next.first_operand  = rs1_data_i;
        next.second_operand = rs2_data_i;
        next.offset         = '0;
        next.rd             = instr[11:7];
        next.tag            = tag_i;
        case (opcode)
            OPC_OP: next.op = alu_decode(funct3, funct7, 1'b0);
            OPC_OP_IMM: begin
                // shift amount sits in the low immediate bits
                next.op             = alu_decode(funct3, funct7, 1'b1);
                next.second_operand = imm_i;
            end
            OPC_LUI: begin
                next.op             = OP_LUI;
                next.second_operand = imm_u;
            end
            OPC_BRANCH: begin
                if (funct3 == 3'b000) begin
                    next.op = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    next.op = OP_BNE;
                end
                next.offset = imm_b;
            end
            OPC_JAL: begin
                next.op     = OP_JAL;
                next.offset = imm_j;
            end
            default: next.op = OP_NOP;
        endcase
        // no destination for branches and nops
        if (next.op inside {OP_NOP, OP_BEQ, OP_BNE}) begin
            next.rd = '0;
        end
    end

    // decode to execute register, nop after reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            decoded_o    <= '0;
            decoded_o.op <= OP_NOP;
        end else if (enable_i) begin
            decoded_o <= next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
// execute, alu and branch resolution, result goes straight to write-back
// wrong-path instructions are dropped when their tag is stale
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  decode_out_t decoded_i,
    output logic        jump_o,
    output word_t       jump_target_o,
    output writeback_t  writeback_o
);

    tag_t       expected_tag_q;
    logic       killed;
    logic       taken;
    logic       writes_rd;
    word_t      result;
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign op_a  = decoded_i.first_operand;
    assign op_b  = decoded_i.second_operand;
    assign shamt = op_b[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // alu and branch compare
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        result    = '0;
        taken     = 1'b0;
        writes_rd = 1'b1;
        case (decoded_i.op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            // immediate already shifted up in decode
            OP_LUI:   result = op_b;
            OP_JAL: begin
                // link value
                result = decoded_i.pc + INSTR_BYTES;
                taken  = 1'b1;
            end
            OP_BEQ: begin
                taken     = (op_a == op_b);
                writes_rd = 1'b0;
            end
            OP_BNE: begin
                taken     = (op_a != op_b);
                writes_rd = 1'b0;
            end
            default: writes_rd = 1'b0;
        endcase
    end

    // branches and jal share the pc relative target
    assign jump_target_o = decoded_i.pc + decoded_i.offset;

    ////////////////////////////////////////////////////////////////////////////
    // kill, jump and write-back
    ////////////////////////////////////////////////////////////////////////////
    assign killed = (decoded_i.tag != expected_tag_q);

    // nothing leaves execute while stalled
    assign jump_o = taken && !killed && !stall_i;

    always_comb begin
        writeback_o.enable = writes_rd && !killed && !stall_i && (decoded_i.rd != '0);
        writeback_o.rd     = decoded_i.rd;
        writeback_o.data   = result;
    end

    // follows the fetch tag, one step per taken jump
    always_ff @(posedge clk) begin
        if (reset_i) begin
            expected_tag_q <= '0;
        end else if (jump_o) begin
            expected_tag_q <= expected_tag_q + 1'b1;
        end
    end

    // fetch loads this target as the next address
    a_target_aligned : assert property (@(posedge clk) disable iff (reset_i)
        jump_o |-> jump_target_o[1:0] == 2'b00)
        else $error("jump target %h not word aligned", jump_target_o);

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
// instruction fetch, program counter with jump redirect and jump tag
// the memory answers one cycle after the address, so pc and tag are delayed
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import rv_core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  enable_i,
    input  logic  jump_i,
    input  word_t jump_target_i,
    output word_t instruction_address_o,
    output word_t pc_o,
    output tag_t  tag_o
);

    word_t pc_q;
    tag_t  tag_q;

    // pc and tag of the word being addressed
    // a jump opens a new tag so the two younger words die in execute
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q  <= RESET_PC;
            tag_q <= '0;
        end else if (jump_i) begin
            pc_q  <= jump_target_i;
            tag_q <= tag_q + 1'b1;
        end else if (enable_i) begin
            pc_q <= pc_q + INSTR_BYTES;
        end
    end

    assign instruction_address_o = pc_q;

    // delayed copy that lines up with instruction_i
    // held under stall together with the memory word kept in decode
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o  <= RESET_PC;
            // word returned during reset is stale, give it a dead tag
            tag_o <= '1;
        end else if (enable_i) begin
            pc_o  <= pc_q;
            tag_o <= tag_q;
        end
    end

    // redirects come from execute, so this also covers its targets
    a_pc_aligned : assert property (@(posedge clk) disable iff (reset_i)
        instruction_address_o[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", instruction_address_o);

endmodule

`default_nettype wire

//--- rtl/register_bank.sv
// integer register file, x1..x31 in flip-flops, x0 reads as zero
// reads see a same-cycle write-back through the bypass
`timescale 1ns/1ps
`default_nettype none

module register_bank
    import rv_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    input  reg_addr_t  rs1_i,
    input  reg_addr_t  rs2_i,
    input  writeback_t writeback_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o
);

    word_t regs_q [1:2**REG_ADDR_W-1];

    // one read port, bypass first
    function automatic word_t read_port(reg_addr_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (writeback_i.enable && writeback_i.rd == idx) begin
            data = writeback_i.data;
        end else begin
            data = regs_q[idx];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    // write at the end of the write-back cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs_q[i] <= '0;
            end
        end else if (writeback_i.enable && writeback_i.rd != '0) begin
            regs_q[writeback_i.rd] <= writeback_i.data;
        end
    end

    // execute filters rd zero before it reaches the bank
    a_no_x0_write : assert property (@(posedge clk) disable iff (reset_i)
        writeback_i.enable |-> writeback_i.rd != '0)
        else $error("write-back enabled for register zero");

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
// top level of the rv32i core, fetch, decode, register bank and execute
// instruction memory sits outside, retired writes are shown on the wb pins
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      stall_i,
    input  word_t     instruction_i,
    output word_t     instruction_address_o,
    output logic      wb_enable_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // pipeline wiring
    ////////////////////////////////////////////////////////////////////////////
    // stall freezes the whole pipe
    logic        pipe_enable;
    logic        jump;
    word_t       jump_target;
    word_t       pc_decode;
    tag_t        tag_decode;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       rs1_data;
    word_t       rs2_data;
    decode_out_t decoded;
    writeback_t  writeback;

    assign pipe_enable = ~stall_i;

    fetch_stage u_fetch (
        .clk                   (clk),
        .reset_i               (reset_i),
        .enable_i              (pipe_enable),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_decode)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .enable_i      (pipe_enable),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_decode),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .decoded_o     (decoded)
    );

    register_bank u_register_bank (
        .clk         (clk),
        .reset_i     (reset_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .writeback_i (writeback),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .decoded_i     (decoded),
        .jump_o        (jump),
        .jump_target_o (jump_target),
        .writeback_o   (writeback)
    );

    // bank write port, unpacked for the pins
    assign wb_enable_o = writeback.enable;
    assign wb_rd_o     = writeback.rd;
    assign wb_data_o   = writeback.data;

endmodule

`default_nettype wire

//--- rtl/rv_core_pkg.sv
// shared widths, encodings and stage records for the rv32i integer core
// imported by wildcard into every core module
`default_nettype none

package rv_core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and constants
    ////////////////////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // jump tag, wraps freely
    localparam int TAG_W      = 3;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;

    // first fetch address after reset
    localparam word_t RESET_PC    = 32'h0000_0000;
    // fetch step, one instruction word
    localparam word_t INSTR_BYTES = 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////
    // major opcodes kept in the subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } rv_opcode_e;

    // internal operations, decode to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        OP_LUI,
        OP_BEQ,
        OP_BNE,
        OP_JAL,
        OP_NOP
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // stage records
    ////////////////////////////////////////////////////////////////////////////
    // decode register contents, 140 bits
    typedef struct packed {
        alu_op_e   op;
        word_t     pc;
        word_t     first_operand;
        word_t     second_operand;
        word_t     offset;
        reg_addr_t rd;
        tag_t      tag;
    } decode_out_t;

    // register bank write, also shown at the pins
    typedef struct packed {
        logic      enable;
        reg_addr_t rd;
        word_t     data;
    } writeback_t;

endpackage

`default_nettype wire

//--- testbench/rv_core_model.svh
// program generator and instruction-level reference model for the core testbench
// included inside the testbench module, fills imem and the expected write and jump lists
`ifndef RV_CORE_MODEL_SVH
`define RV_CORE_MODEL_SVH

// one generated instruction, kept beside its encoding
typedef struct packed {
    alu_op_e   op;
    logic      is_imm;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
} instr_rec_t;

typedef struct packed {
    word_t     pc;
    reg_addr_t rd;
    word_t     data;
} exp_write_t;

typedef struct packed {
    word_t pc;
    word_t target;
} exp_jump_t;

word_t      lcg_state;
word_t      imem [MEM_WORDS];
instr_rec_t prog [MEM_WORDS];
exp_write_t exp_writes[$];
exp_jump_t  exp_jumps[$];

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// upper bits, the low ones of an lcg cycle too fast
function automatic int unsigned rand_below(int unsigned n);
    word_t r;
    r = lcg_next();
    return r[31:16] % n;
endfunction

// x0..x4 only, so most instructions depend on a recent one
function automatic reg_addr_t pick_reg();
    return reg_addr_t'(rand_below(5));
endfunction

////////////////////////////////////////////////////////////////////////////
// encoding, straight from the isa tables
////////////////////////////////////////////////////////////////////////////
function automatic logic [2:0] funct3_of(alu_op_e op);
    case (op)
        ALU_SLL, OP_BNE:  return 3'b001;
        ALU_SLT:          return 3'b010;
        ALU_SLTU:         return 3'b011;
        ALU_XOR:          return 3'b100;
        ALU_SRL, ALU_SRA: return 3'b101;
        ALU_OR:           return 3'b110;
        ALU_AND:          return 3'b111;
        default:          return 3'b000;
    endcase
endfunction

function automatic word_t encode_instr(instr_rec_t r);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (r.op inside {ALU_SUB, ALU_SRA}) ? 7'b0100000 : 7'b0000000;
    f3 = funct3_of(r.op);
    case (r.op)
        OP_LUI: return {r.imm[31:12], r.rd, OPC_LUI};
        OP_JAL: return {r.imm[20], r.imm[10:1], r.imm[11], r.imm[19:12], r.rd, OPC_JAL};
        OP_BEQ, OP_BNE: begin
            return {r.imm[12], r.imm[10:5], r.rs2, r.rs1, f3, r.imm[4:1], r.imm[11],
                    OPC_BRANCH};
        end
        default: begin
            if (!r.is_imm) begin
                return {f7, r.rs2, r.rs1, f3, r.rd, OPC_OP};
            end else if (r.op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                // shamt in the low immediate bits, funct7 above it
                return {f7, r.imm[4:0], r.rs1, f3, r.rd, OPC_OP_IMM};
            end
            return {r.imm[11:0], r.rs1, f3, r.rd, OPC_OP_IMM};
        end
    endcase
endfunction

// random program, forward jumps of 3 to 5 words, ends in jal x0, 0
task automatic build_program(bit with_jumps);
    instr_rec_t  r;
    int unsigned kind;
    int unsigned words;
    word_t       raw;
    for (int i = 0; i < MEM_WORDS; i++) begin
        prog[i] = '0;
        imem[i] = '0;
    end
    for (int i = 0; i < PROG_LEN - 1; i++) begin
        r       = '0;
        r.rd    = pick_reg();
        r.rs1   = pick_reg();
        r.rs2   = pick_reg();
        kind    = rand_below(with_jumps ? 10 : 8);
        words   = 3 + rand_below(3);
        raw     = lcg_next();
        if (kind >= 8 && i + words <= PROG_LEN - 1) begin
            r.op  = (kind == 9) ? OP_JAL : ((raw[20]) ? OP_BEQ : OP_BNE);
            r.imm = words * INSTR_BYTES;
        end else if (kind == 7) begin
            r.op     = OP_LUI;
            r.is_imm = 1'b1;
            r.imm    = {raw[31:12], 12'b0};
        end else begin
            // the ten alu operations open the enum
            r.op     = alu_op_e'(rand_below(10));
            r.is_imm = (rand_below(2) == 1) && (r.op != ALU_SUB);
            if (r.op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                r.imm = word_t'(raw[4:0]);
            end else begin
                r.imm = {{20{raw[11]}}, raw[11:0]};
            end
        end
        prog[i] = r;
    end
    // final self loop, no link
    r        = '0;
    r.op     = OP_JAL;
    prog[PROG_LEN-1] = r;
    for (int i = 0; i < PROG_LEN; i++) begin
        imem[i] = encode_instr(prog[i]);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////
function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    case (op)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a - b;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        ALU_SLL:  return a << b[4:0];
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
        // lui, value is the immediate itself
        default:  return b;
    endcase
endfunction

// runs the program up to the final loop, records writes and taken jumps in order
task automatic run_model();
    word_t       regs [32];
    instr_rec_t  r;
    int unsigned i;
    word_t       a;
    word_t       b;
    word_t       res;
    logic        taken;
    exp_write_t  w;
    exp_jump_t   j;
    exp_writes.delete();
    exp_jumps.delete();
    foreach (regs[k]) begin
        regs[k] = '0;
    end
    i = 0;
    while (i < PROG_LEN - 1) begin
        r     = prog[i];
        a     = regs[r.rs1];
        b     = r.is_imm ? r.imm : regs[r.rs2];
        res   = ref_alu(r.op, a, b);
        taken = 1'b0;
        case (r.op)
            OP_BEQ: taken = (a == b);
            OP_BNE: taken = (a != b);
            OP_JAL: begin
                taken = 1'b1;
                res   = word_t'(i * 4 + 4);
            end
            default: taken = 1'b0;
        endcase
        if (!(r.op inside {OP_BEQ, OP_BNE}) && r.rd != '0) begin
            w.pc    = word_t'(i * 4);
            w.rd    = r.rd;
            w.data  = res;
            regs[r.rd] = res;
            exp_writes.push_back(w);
        end
        if (taken) begin
            j.pc     = word_t'(i * 4);
            j.target = word_t'(i * 4) + r.imm;
            exp_jumps.push_back(j);
            i = i + r.imm / 4;
        end else begin
            i = i + 1;
        end
    end
endtask

`endif

//--- testbench/tb_rv_core.sv
// testbench for the rv32i core, random programs checked against an instruction-level model
// inputs change on the falling edge, pins are sampled at the rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int MEM_WORDS    = 64;
    localparam int PROG_LEN     = 48;
    localparam int WB_TIMEOUT   = 1000;
    localparam int LOOP_TIMEOUT = 32;

    logic      clk;
    logic      reset_i;
    logic      stall_i;
    word_t     instruction_i;
    word_t     instruction_address_o;
    logic      wb_enable_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;

    `include "rv_core_model.svh"

    // run bookkeeping
    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    // pipeline tracking, addresses of the last two unstalled cycles
    word_t       issued[$];
    int unsigned wb_seen;
    int unsigned wb_count;
    int unsigned jump_idx;
    int unsigned cycle_no;
    logic        jump_pending;
    word_t       jump_target_exp;
    word_t       last_addr;
    logic        last_stall;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    rv_core u_rv_core (
        .clk                   (clk),
        .reset_i               (reset_i),
        .stall_i               (stall_i),
        .instruction_i         (instruction_i),
        .instruction_address_o (instruction_address_o),
        .wb_enable_o           (wb_enable_o),
        .wb_rd_o               (wb_rd_o),
        .wb_data_o             (wb_data_o)
    );

    task automatic check_value(string name, word_t expected, word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // words past the memory read as zero, which decodes as nop
    function automatic word_t read_imem(word_t addr);
        if ((addr >> 2) < MEM_WORDS) begin
            return imem[addr >> 2];
        end
        return '0;
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        reset_i = 1'b1;
        stall_i = 1'b0;
        repeat (2) @(negedge clk);
        reset_i       = 1'b0;
        // address was RESET_PC throughout reset
        instruction_i = read_imem(RESET_PC);
        issued.delete();
        wb_seen      = 0;
        wb_count     = 0;
        jump_idx     = 0;
        cycle_no     = 0;
        jump_pending = 1'b0;
        last_addr    = RESET_PC;
        last_stall   = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one clock, sample and check at the rising edge, drive at the falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic step_cycle(int unsigned stall_pct);
        word_t      addr;
        word_t      exec_pc;
        logic       have_exec;
        logic       stall_now;
        logic       expect_wb;
        exp_write_t w;
        @(posedge clk);
        addr      = instruction_address_o;
        stall_now = stall_i;
        if (cycle_no == 0) begin
            check_value("instruction_address_o", RESET_PC, addr);
            check_value("wb_enable_o", 1'b0, wb_enable_o);
        end else if (last_stall) begin
            // pc frozen by the stall
            check_value("instruction_address_o", last_addr, addr);
        end
        if (jump_pending) begin
            check_value("instruction_address_o", jump_target_exp, addr);
            jump_pending = 1'b0;
        end
        // executing now, the address issued two unstalled cycles back
        have_exec = (issued.size() >= 2);
        exec_pc   = have_exec ? issued[issued.size()-2] : '0;
        expect_wb = have_exec && !stall_now && (wb_seen < exp_writes.size())
                    && (exp_writes[wb_seen].pc == exec_pc);
        check_value("wb_enable_o", expect_wb, wb_enable_o);
        if (expect_wb) begin
            w = exp_writes[wb_seen];
            check_value("wb_rd_o", w.rd, wb_rd_o);
            check_value("wb_data_o", w.data, wb_data_o);
            wb_seen++;
        end
        if (wb_enable_o) begin
            wb_count++;
        end
        // taken jump in execute, target due on the next cycle
        if (have_exec && !stall_now && jump_idx < exp_jumps.size()
            && exp_jumps[jump_idx].pc == exec_pc) begin
            jump_pending    = 1'b1;
            jump_target_exp = exp_jumps[jump_idx].target;
            jump_idx++;
        end
        if (!stall_now) begin
            issued.push_back(addr);
            if (issued.size() > 2) begin
                void'(issued.pop_front());
            end
        end
        last_addr  = addr;
        last_stall = stall_now;
        cycle_no++;
        @(negedge clk);
        instruction_i = read_imem(addr);
        stall_i       = (rand_below(100) < stall_pct);
    endtask

    task automatic run_test(string name, bit with_jumps, int unsigned stall_pct);
        int    errors_before;
        int    waited;
        logic  timed_out;
        word_t loop_pc;
        errors_before = error_count;
        timed_out     = 1'b0;
        loop_pc       = (PROG_LEN - 1) * INSTR_BYTES;
        build_program(with_jumps);
        run_model();
        apply_reset();
        waited = 0;
        while (wb_seen < exp_writes.size() && waited < WB_TIMEOUT) begin
            step_cycle(stall_pct);
            waited++;
        end
        if (wb_seen < exp_writes.size()) begin
            $display("%s: timed out waiting for write-backs, saw %0d of %0d", name, wb_seen,
                     exp_writes.size());
            error_count++;
            timed_out = 1'b1;
        end
        waited = 0;
        while (!timed_out && last_addr != loop_pc && waited < LOOP_TIMEOUT) begin
            step_cycle(stall_pct);
            waited++;
        end
        if (!timed_out && last_addr != loop_pc) begin
            $display("%s: timed out waiting for the fetch address to reach the final loop", name);
            error_count++;
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            // a few turns of the loop, nothing more may retire
            // fetch stays on the loop word and its two wrong-path successors
            for (int k = 0; k < 12; k++) begin
                step_cycle(stall_pct);
                if (last_addr - loop_pc > 2 * INSTR_BYTES) begin
                    check_value("instruction_address_o", loop_pc, last_addr);
                end
            end
            check_value("write-back count", exp_writes.size(), wb_count);
            check_value("taken jump count", exp_jumps.size(), jump_idx);
        end
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("test %s: %0d write-backs, %0d jumps, %0d errors", name, wb_count,
                 jump_idx, error_count - errors_before);
    endtask

    initial begin
        reset_i       = 1'b1;
        stall_i       = 1'b0;
        instruction_i = '0;
        lcg_state     = 32'h8f0c;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        run_test("straight_line", 1'b0, 0);
        run_test("jumps", 1'b1, 0);
        run_test("random_stall", 1'b1, 15);
        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_count, failed_tests,
                 check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
